// File: binary_neuron.f
+incdir+hw
hw/neuron_pkg.sv
hw/operand_capture.sv
hw/sign_lane.sv
hw/sum_stage.sv
hw/binary_neuron.sv
tb/binary_neuron_sva.sv
tb/binary_neuron_tb.sv

// File: hw/binary_neuron.sv
`timescale 1ns/10ps
`include "neuron_config.svh"

module binary_neuron (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  neuron_pkg::neuron_req_t in_req,
    output logic                    out_valid,
    input  logic                    out_ready,
    output neuron_pkg::neuron_sum_t out_sum
);

    import neuron_pkg::*;

    logic      cap_valid;
    logic      cap_ready;
    logic      cap_bias;
    logic      advance;
    lane_ops_t cap_ops [`LANE_COUNT];
    part_sum_t parts [`LANE_COUNT];

    // Stage one
    operand_capture u_operand_capture (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .cap_valid (cap_valid),
        .cap_ready (cap_ready),
        .cap_ops   (cap_ops),
        .cap_bias  (cap_bias)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Lanes load together on advance
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
        sign_lane u_sign_lane (
            .clk     (clk),
            .advance (advance),
            .ops     (cap_ops[g]),
            .part    (parts[g])
        );
    end

    // Stage two control and output register
    sum_stage u_sum_stage (
        .clk       (clk),
        .reset     (reset),
        .cap_valid (cap_valid),
        .cap_bias  (cap_bias),
        .cap_ready (cap_ready),
        .advance   (advance),
        .parts     (parts),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

endmodule

// File: hw/neuron_config.svh
`ifndef NEURON_CONFIG_SVH
`define NEURON_CONFIG_SVH

// Neuron geometry
`define NEURON_INPUTS 64
`define ACT_WIDTH     4

// LANE_COUNT * LANE_INPUTS must equal NEURON_INPUTS
`define LANE_COUNT    8
`define LANE_INPUTS   8

// Lane partial sum covers -64..56
`define PART_WIDTH    8

// Result wraps modulo 1024
`define SUM_WIDTH     10

`endif

// File: hw/neuron_pkg.sv
`include "neuron_config.svh"

package neuron_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [`ACT_WIDTH-1:0] act_t;

    typedef logic signed [`PART_WIDTH-1:0] part_sum_t;

    typedef logic signed [`SUM_WIDTH-1:0] neuron_sum_t;

    ////////////////////////////////////////////////////////////////////////////
    // Request and lane operands
    ////////////////////////////////////////////////////////////////////////////

    // Element 0 sits in the top bits of act and weight
    typedef struct packed {
        act_t [0:`NEURON_INPUTS-1] act;
        logic [0:`NEURON_INPUTS-1] weight;
        logic                      bias;
    } neuron_req_t;

    // One lane worth of activations and weight bits
    typedef struct packed {
        act_t [0:`LANE_INPUTS-1] act;
        logic [0:`LANE_INPUTS-1] weight;
    } lane_ops_t;

endpackage

// File: hw/operand_capture.sv
`timescale 1ns/10ps
`include "neuron_config.svh"

module operand_capture (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  neuron_pkg::neuron_req_t in_req,
    output logic                    cap_valid,
    input  logic                    cap_ready,
    output neuron_pkg::lane_ops_t   cap_ops [`LANE_COUNT],
    output logic                    cap_bias
);

    import neuron_pkg::*;

    neuron_req_t held_req;

    // Slot is free when empty or when the held request moves on
    assign in_ready = !cap_valid || cap_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            cap_valid <= 1'b0;
        end else if (in_ready) begin
            cap_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_req <= in_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Regroup flat vectors into lanes
    ////////////////////////////////////////////////////////////////////////////

    // Lane l takes inputs l*LANE_INPUTS .. l*LANE_INPUTS+LANE_INPUTS-1
    always_comb begin
        for (int l = 0; l < `LANE_COUNT; l++) begin
            for (int j = 0; j < `LANE_INPUTS; j++) begin
                cap_ops[l].act[j]    = held_req.act[l*`LANE_INPUTS + j];
                cap_ops[l].weight[j] = held_req.weight[l*`LANE_INPUTS + j];
            end
        end
    end

    assign cap_bias = held_req.bias;

endmodule

// File: hw/sign_lane.sv
`timescale 1ns/10ps
`include "neuron_config.svh"

module sign_lane (
    input  logic                  clk,
    input  logic                  advance,
    input  neuron_pkg::lane_ops_t ops,
    output neuron_pkg::part_sum_t part
);

    import neuron_pkg::*;

    act_t      prod [`LANE_INPUTS];
    part_sum_t lane_sum;

    ////////////////////////////////////////////////////////////////////////////
    // Binary weight products
    ////////////////////////////////////////////////////////////////////////////

    // Weight 0 negates in 4 bits, so -8 stays -8
    always_comb begin
        for (int j = 0; j < `LANE_INPUTS; j++) begin
            if (ops.weight[j]) begin
                prod[j] = ops.act[j];
            end else begin
                prod[j] = act_t'(-ops.act[j]);
            end
        end
    end

    // Sign extend and accumulate
    always_comb begin
        lane_sum = '0;
        for (int j = 0; j < `LANE_INPUTS; j++) begin
            lane_sum = lane_sum + part_sum_t'(prod[j]);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            part <= lane_sum;
        end
    end

endmodule

// File: hw/sum_stage.sv
`timescale 1ns/10ps
`include "neuron_config.svh"

module sum_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cap_valid,
    input  logic                    cap_bias,
    output logic                    cap_ready,
    output logic                    advance,
    input  neuron_pkg::part_sum_t   parts [`LANE_COUNT],
    output logic                    out_valid,
    input  logic                    out_ready,
    output neuron_pkg::neuron_sum_t out_sum
);

    import neuron_pkg::*;

    logic        s2_valid;
    logic        s2_bias;
    logic        out_free;
    logic        out_load;
    neuron_sum_t total;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake control
    ////////////////////////////////////////////////////////////////////////////

    // Output register empty or being read this cycle
    assign out_free = !out_valid || out_ready;
    assign out_load = s2_valid && out_free;

    // Stage two can take new partials when empty or draining
    assign cap_ready = !s2_valid || out_load;
    assign advance   = cap_valid && cap_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (cap_ready) begin
            s2_valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (out_free) begin
            out_valid <= s2_valid;
        end
    end

    // Bias travels with the lane partials
    always_ff @(posedge clk) begin
        if (advance) begin
            s2_bias <= cap_bias;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Final adder
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (s2_bias) begin
            total = neuron_sum_t'(1);
        end else begin
            total = neuron_sum_t'(-1);
        end
        for (int l = 0; l < `LANE_COUNT; l++) begin
            total = total + neuron_sum_t'(parts[l]);
        end
    end

    // Wraps modulo 1024 by width
    always_ff @(posedge clk) begin
        if (out_load) begin
            out_sum <= total;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the neuron testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f binary_neuron.f \
    --top-module binary_neuron_tb \
    -Mdir "$OBJ" -o binary_neuron_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

"./$OBJ/binary_neuron_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: tb/binary_neuron_sva.sv
`timescale 1ns/10ps

module binary_neuron_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    out_valid,
    input logic                    out_ready,
    input neuron_pkg::neuron_sum_t out_sum,
    input logic                    cap_valid,
    input logic                    advance
);

    import neuron_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Output stream
    ////////////////////////////////////////////////////////////////////////////

    // Stalled result stays put
    out_hold_a : assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_sum)
    ) else $error("out_valid or out_sum changed under a stall");

    out_reset_a : assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

    ////////////////////////////////////////////////////////////////////////////
    // Lane advance
    ////////////////////////////////////////////////////////////////////////////

    // Captured operands wait until the lanes take them
    cap_hold_a : assert property (
        @(posedge clk) disable iff (reset)
        cap_valid && !advance |=> cap_valid
    ) else $error("captured operands dropped before the lanes advanced");

endmodule

// File: tb/binary_neuron_tb.sv
`timescale 1ns/10ps

module binary_neuron_tb;

    import neuron_pkg::*;

    localparam int MAX_VECTORS = 64;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    neuron_req_t in_req;
    logic        out_valid;
    logic        out_ready;
    neuron_sum_t out_sum;

    neuron_req_t vec_req [MAX_VECTORS];
    neuron_sum_t vec_sum [MAX_VECTORS];
    int          vec_count;
    neuron_sum_t expected_q [$];
    int          index_q [$];
    int          cycle_count;
    int          timeout_limit;
    integer      seed;

    binary_neuron u_binary_neuron (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

    bind binary_neuron binary_neuron_sva u_binary_neuron_sva (.*);

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_sum(input string name, input neuron_sum_t exp, input neuron_sum_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic load_vectors;
        int           fd;
        int           code;
        string        line;
        logic [255:0] act_bits;
        logic [63:0]  weight_bits;
        logic [3:0]   bias_bits;
        logic [11:0]  sum_bits;
        fd = $fopen("tb/neuron_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file tb/neuron_stim.txt");
        end
        vec_count = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%h %h %h %h", act_bits, weight_bits, bias_bits, sum_bits);
                if (code == 4 && vec_count < MAX_VECTORS) begin
                    vec_req[vec_count].act    = act_bits;
                    vec_req[vec_count].weight = weight_bits;
                    vec_req[vec_count].bias   = bias_bits[0];
                    vec_sum[vec_count]        = sum_bits[9:0];
                    vec_count++;
                end
            end
        end
        $fclose(fd);
        if (vec_count == 0) begin
            fail_run("The stimulus file holds no vectors");
        end
    endtask

    // Step to the next falling edge where inputs change
    task automatic next_cycle;
        @(negedge clk);
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            fail_run("Timeout: the results did not all arrive in time");
        end
    endtask

    task automatic push_expected(input int idx);
        expected_q.push_back(vec_sum[idx]);
        index_q.push_back(idx);
    endtask

    task automatic take_result(input string phase);
        neuron_sum_t exp;
        int          idx;
        if (expected_q.size() == 0) begin
            fail_run("A result came out with no input pending");
        end
        exp = expected_q.pop_front();
        idx = index_q.pop_front();
        check_sum($sformatf("%s vector %0d", phase, idx), exp, out_sum);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test phases
    ////////////////////////////////////////////////////////////////////////////

    // Full rate without stalls
    task automatic run_burst;
        int sent;
        int got;
        int first_accept;
        int first_out;
        sent = 0;
        got = 0;
        first_accept = -1;
        first_out = -1;
        while (got < vec_count) begin
            next_cycle();
            out_ready = 1'b1;
            in_valid  = sent < vec_count;
            if (sent < vec_count) begin
                in_req = vec_req[sent];
            end
            #10;
            if (sent < vec_count) begin
                check_bit("burst in_ready", 1'b1, in_ready);
            end
            if (in_valid && in_ready) begin
                if (first_accept < 0) begin
                    first_accept = cycle_count;
                end
                push_expected(sent);
                sent++;
            end
            if (first_out >= 0) begin
                check_bit("burst out_valid", 1'b1, out_valid);
            end
            if (out_valid && out_ready) begin
                if (first_out < 0) begin
                    first_out = cycle_count;
                    if (first_out - first_accept != 3) begin
                        fail_run("The first result did not arrive three cycles after accept");
                    end
                end
                take_result("burst");
                got++;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic run_random;
        int   sent;
        int   got;
        logic holding;
        sent = 0;
        got = 0;
        holding = 1'b0;
        while (got < vec_count) begin
            next_cycle();
            out_ready = ($random(seed) & 1) != 0;
            if (!holding && sent < vec_count) begin
                holding = ($random(seed) & 3) != 0;
            end
            in_valid = holding;
            if (holding) begin
                in_req = vec_req[sent];
            end
            #10;
            // Input side blocks only with three items inside and a stalled output
            check_bit("random in_ready", (sent - got < 3) || out_ready, in_ready);
            if (in_valid && in_ready) begin
                push_expected(sent);
                sent++;
                holding = 1'b0;
            end
            if (out_valid && out_ready) begin
                take_result("random");
                got++;
            end
        end
        in_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_req      = '0;
        out_ready   = 1'b0;
        seed        = 39474;
        cycle_count = 0;
        load_vectors();
        // Two passes over the vectors
        timeout_limit = 10 * 2 * vec_count + 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #10;
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset in_ready", 1'b1, in_ready);
        run_burst();
        run_random();
        next_cycle();
        if (expected_q.size() != 0 || out_valid) begin
            fail_run("Results left over at the end of the run");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

// File: tb/neuron_stim.txt
# activations (64 x 4 bit, element 0 first)  weights (bit 63 = weight 0)  bias  expected sum
# all fields in hex
0000000000000000000000000000000000000000000000000000000000000000 FFFFFFFFFFFFFFFF 1 001
0000000000000000000000000000000000000000000000000000000000000000 FFFFFFFFFFFFFFFF 0 3FF
1111111111111111111111111111111111111111111111111111111111111111 FFFFFFFFFFFFFFFF 1 041
1111111111111111111111111111111111111111111111111111111111111111 0000000000000000 0 3BF
7777777777777777777777777777777777777777777777777777777777777777 FFFFFFFFFFFFFFFF 1 1C1
7777777777777777777777777777777777777777777777777777777777777777 0000000000000000 1 241
8888888888888888888888888888888888888888888888888888888888888888 FFFFFFFFFFFFFFFF 0 1FF
8888888888888888888888888888888888888888888888888888888888888888 0000000000000000 1 201
8888888888888888888888888888888888888888888888888888888888888888 AAAAAAAAAAAAAAAA 1 201
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1 3C1
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000000000000000 0 03F
3333333333333333333333333333333333333333333333333333333333333333 AAAAAAAAAAAAAAAA 1 001
3333333333333333333333333333333333333333333333333333333333333333 FF00FF00FF00FF00 0 3FF
5555555555555555555555555555555555555555555555555555555555555555 F000F000F000F000 1 361
2222222222222222222222222222222222222222222222222222222222222222 0123456789ABCDEF 0 3FF
6666666666666666666666666666666666666666666666666666666666666666 FFFFFFFFFFFF0000 1 0C1
CCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCC FFFFFFFFFFFFFFF0 0 31F
4444444444444444444444444444444444444444444444444444444444444444 8000000000000000 1 309
9999999999999999999999999999999999999999999999999999999999999999 7FFFFFFFFFFFFFFF 1 24F
EEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEEE 0000000000000001 0 07B
AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA FFFF000000000000 0 0BF
BBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBBB 0F0F0F0F0F0F0FFF 1 3D9
DDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDD FFFFFFFFFF000000 0 3CF
0123456701234567012345670123456701234567012345670123456701234567 FFFFFFFFFFFFFFFF 1 0E1
0123456701234567012345670123456701234567012345670123456701234567 0000000000000000 0 31F
89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF FFFFFFFFFFFFFFFF 1 2E1
89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF 0000000000000000 1 0A1
0123456701234567012345670123456701234567012345670123456701234567 FF00FF00FF00FF00 0 3FF
0123456701234567012345670123456701234567012345670123456701234567 F0F0F0F0F0F0F0F0 1 381
89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF F0F0F0F0F0F0F0F0 0 37F
89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF89ABCDEF 0F0F0F0F0F0F0F0F 1 001
7654321076543210765432107654321076543210765432107654321076543210 AAAAAAAAAAAAAAAA 1 021
7654321076543210765432107654321076543210765432107654321076543210 5555555555555555 0 3DF
7777777777777777777777777777777777777777777777777777777777777777 FF00000000000000 1 2B1
8888888888888888888888888888888877777777777777777777777777777777 FFFFFFFFFFFFFFFF 1 3E1
8888888888888888888888888888888877777777777777777777777777777777 0000000000000000 0 21F
11111111111111111111111111111111FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0 3FF
0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF FFFFFFFFFFFFFFFF 1 3E1
0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF 0000000000000000 0 3DF
7777777777777777777777777777777777777777777777777777777777777777 FFFFFFFFFFFFFFFF 0 1BF
